// File: hw/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// word and address width
`define DC_XLEN 32

// address split, tag | index | offset
`define DC_TAG_W 22
`define DC_INDEX_W 4
`define DC_OFFSET_W 6

// geometry, 16 lines of 64 bytes
`define DC_LINES 16
`define DC_LINE_WORDS 16

// one count per word of a line burst
`define DC_BEAT_W 4

// device region, selected by the top address nibble
`define DC_UNCACHE_NIBBLE 4'hA

`endif

// File: hw/dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

  typedef struct packed {
    logic [`DC_TAG_W-1:0]               tag;
    logic [`DC_INDEX_W-1:0]             index;
    logic [`DC_BEAT_W-1:0]              word_sel;
    logic [`DC_OFFSET_W-`DC_BEAT_W-1:0] byte_sel;
  } dc_addr_fields_t;

  // cpu address, flat or split into fields
  typedef union packed {
    logic [`DC_XLEN-1:0] flat;
    dc_addr_fields_t     fld;
  } dc_addr_u;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    dc_addr_u              addr;
    logic [`DC_XLEN-1:0]   wdata;
    logic [`DC_XLEN/8-1:0] strb;
  } cpu_req_t;

  typedef struct packed {
    logic                done;
    logic [`DC_XLEN-1:0] rdata;
  } cpu_resp_t;

  typedef struct packed {
    logic                  valid;
    logic [`DC_XLEN-1:0]   addr;
    logic [`DC_BEAT_W-1:0] len;  // beats minus one
  } mem_rd_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`DC_XLEN-1:0]   addr;
    logic [`DC_BEAT_W-1:0] len;
    logic [`DC_XLEN-1:0]   data;
    logic [`DC_XLEN/8-1:0] strb;
  } mem_wr_req_t;

  typedef struct packed {
    logic                ready;
    logic [`DC_XLEN-1:0] data;
  } mem_rd_rsp_t;

  typedef struct packed {
    logic ready;
  } mem_wr_rsp_t;

  // word location inside the data store
  typedef struct packed {
    logic [`DC_INDEX_W-1:0] index;
    logic [`DC_BEAT_W-1:0]  word;
  } dc_waddr_t;

  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [`DC_TAG_W-1:0] tag;
  } tag_entry_t;

  typedef enum logic [2:0] {
    IDLE,
    RESP,
    WRITE_BACK,
    REFILL,
    UNC_READ,
    UNC_WRITE
  } dc_state_e;

endpackage

// File: hw/dcache_tag_array.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tag_array (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`DC_INDEX_W-1:0] index_i,
  input  logic [`DC_TAG_W-1:0]   tag_i,
  input  logic                   we_i,
  input  logic                   dirty_i,
  output logic                   hit_o,
  output logic [`DC_TAG_W-1:0]   victim_tag_o,
  output logic                   victim_dirty_o
);
  import dcache_pkg::*;

  tag_entry_t entry_q [`DC_LINES];
  tag_entry_t rd_entry;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `DC_LINES; i++) begin
        entry_q[i].valid <= 1'b0;
      end
    end else if (we_i) begin
      entry_q[index_i] <= '{valid: 1'b1, dirty: dirty_i, tag: tag_i};
    end
  end

  assign rd_entry = entry_q[index_i];

  assign hit_o          = rd_entry.valid && (rd_entry.tag == tag_i);
  assign victim_tag_o   = rd_entry.tag;
  assign victim_dirty_o = rd_entry.valid && rd_entry.dirty;  // invalid lines never write back

  a_hit_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(hit_o))
    else $error("hit unknown at index %0d", index_i);

endmodule

// File: hw/dcache_data_array.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_data_array (
  input  logic                  clk,
  input  dcache_pkg::dc_waddr_t addr_i,
  input  logic                  we_i,
  input  logic [`DC_XLEN-1:0]   wdata_i,
  input  logic [`DC_XLEN/8-1:0] strb_i,
  output logic [`DC_XLEN-1:0]   rdata_o
);
  import dcache_pkg::*;

  // one word per line and word select
  localparam int unsigned DEPTH = 2 ** $bits(dc_waddr_t);

  logic [`DC_XLEN-1:0] mem_q [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < `DC_XLEN / 8; b++) begin
        if (strb_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  assign rdata_o = mem_q[addr_i];  // combinational read

endmodule

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  dcache_pkg::cpu_req_t    cpu_req_i,
  output dcache_pkg::cpu_resp_t   cpu_resp_o,
  output dcache_pkg::mem_rd_req_t mem_rd_req_o,
  input  dcache_pkg::mem_rd_rsp_t mem_rd_rsp_i,
  output dcache_pkg::mem_wr_req_t mem_wr_req_o,
  input  dcache_pkg::mem_wr_rsp_t mem_wr_rsp_i,
  input  logic                    hit_i,
  input  logic [`DC_TAG_W-1:0]    victim_tag_i,
  input  logic                    victim_dirty_i,
  input  logic [`DC_XLEN-1:0]     rdata_word_i,
  output logic [`DC_INDEX_W-1:0]  tag_index_o,
  output logic                    tag_we_o,
  output logic                    tag_dirty_o,
  output logic [`DC_TAG_W-1:0]    tag_value_o,
  output dcache_pkg::dc_waddr_t   data_addr_o,
  output logic                    data_we_o,
  output logic [`DC_XLEN-1:0]     data_wdata_o,
  output logic [`DC_XLEN/8-1:0]   data_strb_o
);
  import dcache_pkg::*;

  localparam int unsigned LINE_LEN_I = `DC_LINE_WORDS - 1;
  localparam logic [`DC_BEAT_W-1:0] LINE_LEN = LINE_LEN_I[`DC_BEAT_W-1:0];

  dc_state_e             state_q;
  dc_state_e             state_d;
  logic [`DC_BEAT_W-1:0] beat_q;
  logic [`DC_XLEN-1:0]   unc_rdata_q;

  logic uncached;
  logic rd_fire;
  logic wr_fire;
  logic rd_last;
  logic wr_last;
  logic in_burst;
  logic write_hit;
  logic refill_done;

  assign uncached = cpu_req_i.addr.flat[`DC_XLEN-1 -: 4] == `DC_UNCACHE_NIBBLE;

  assign rd_fire = mem_rd_req_o.valid && mem_rd_rsp_i.ready;
  assign wr_fire = mem_wr_req_o.valid && mem_wr_rsp_i.ready;
  assign rd_last = beat_q == mem_rd_req_o.len;  // single beats see len 0
  assign wr_last = beat_q == mem_wr_req_o.len;

  assign in_burst    = (state_q == WRITE_BACK) || (state_q == REFILL);
  assign write_hit   = (state_q == RESP) && cpu_req_i.write && !uncached;
  assign refill_done = (state_q == REFILL) && rd_fire && rd_last;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cpu_req_i.valid) begin
          if (uncached) begin
            state_d = cpu_req_i.write ? UNC_WRITE : UNC_READ;
          end else if (hit_i) begin
            state_d = RESP;
          end else if (victim_dirty_i) begin
            state_d = WRITE_BACK;
          end else begin
            state_d = REFILL;
          end
        end
      end
      RESP: begin
        state_d = IDLE;
      end
      WRITE_BACK: begin
        if (wr_fire && wr_last) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (refill_done) begin
          state_d = IDLE;  // lookup again, now hits
        end
      end
      UNC_READ: begin
        if (rd_fire) begin
          state_d = RESP;
        end
      end
      UNC_WRITE: begin
        if (wr_fire) begin
          state_d = RESP;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      if (in_burst && (rd_fire || wr_fire)) begin
        beat_q <= beat_q + `DC_BEAT_W'd1;  // wraps to 0 after the last beat
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == UNC_READ) && rd_fire) begin
      unc_rdata_q <= mem_rd_rsp_i.data;
    end
  end

  always_comb begin
    mem_rd_req_o = '0;
    mem_wr_req_o = '0;
    case (state_q)
      REFILL: begin
        mem_rd_req_o.valid = 1'b1;
        mem_rd_req_o.addr  = {cpu_req_i.addr.fld.tag, cpu_req_i.addr.fld.index,
                              {`DC_OFFSET_W{1'b0}}};
        mem_rd_req_o.len   = LINE_LEN;
      end
      UNC_READ: begin
        mem_rd_req_o.valid = 1'b1;
        mem_rd_req_o.addr  = cpu_req_i.addr.flat;
      end
      WRITE_BACK: begin
        mem_wr_req_o.valid = 1'b1;
        mem_wr_req_o.addr  = {victim_tag_i, cpu_req_i.addr.fld.index, {`DC_OFFSET_W{1'b0}}};
        mem_wr_req_o.len   = LINE_LEN;
        mem_wr_req_o.data  = rdata_word_i;  // word at the current beat
        mem_wr_req_o.strb  = '1;
      end
      UNC_WRITE: begin
        mem_wr_req_o.valid = 1'b1;
        mem_wr_req_o.addr  = cpu_req_i.addr.flat;
        mem_wr_req_o.data  = cpu_req_i.wdata;
        mem_wr_req_o.strb  = cpu_req_i.strb;
      end
      default: begin
      end
    endcase
  end

  assign data_addr_o = '{index: cpu_req_i.addr.fld.index,
                         word:  in_burst ? beat_q : cpu_req_i.addr.fld.word_sel};
  assign data_we_o    = ((state_q == REFILL) && rd_fire) || write_hit;
  assign data_wdata_o = (state_q == REFILL) ? mem_rd_rsp_i.data : cpu_req_i.wdata;
  assign data_strb_o  = (state_q == REFILL) ? '1 : cpu_req_i.strb;

  assign tag_index_o = cpu_req_i.addr.fld.index;
  assign tag_value_o = cpu_req_i.addr.fld.tag;
  assign tag_we_o    = refill_done || write_hit;
  assign tag_dirty_o = write_hit;  // a fill leaves the line clean

  assign cpu_resp_o = '{done:  state_q == RESP,
                        rdata: uncached ? unc_rdata_q : rdata_word_i};

  a_no_dual_valid: assert property (@(posedge clk) disable iff (rst)
    !(mem_rd_req_o.valid && mem_wr_req_o.valid))
    else $error("read and write valid high together");

  a_rd_hold: assert property (@(posedge clk) disable iff (rst)
    mem_rd_req_o.valid && !(mem_rd_rsp_i.ready && rd_last) |=> mem_rd_req_o.valid)
    else $error("read valid dropped before last beat");

  a_wr_hold: assert property (@(posedge clk) disable iff (rst)
    mem_wr_req_o.valid && !(mem_wr_rsp_i.ready && wr_last) |=> mem_wr_req_o.valid)
    else $error("write valid dropped before last beat");

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    cpu_resp_o.done |=> !cpu_resp_o.done)
    else $error("done held for two cycles");

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top (
  input  logic                    clk,
  input  logic                    rst,
  input  dcache_pkg::cpu_req_t    cpu_req_i,
  output dcache_pkg::cpu_resp_t   cpu_resp_o,
  output dcache_pkg::mem_rd_req_t mem_rd_req_o,
  input  dcache_pkg::mem_rd_rsp_t mem_rd_rsp_i,
  output dcache_pkg::mem_wr_req_t mem_wr_req_o,
  input  dcache_pkg::mem_wr_rsp_t mem_wr_rsp_i
);
  import dcache_pkg::*;

  logic                  hit;
  logic [`DC_TAG_W-1:0]  victim_tag;
  logic                  victim_dirty;
  logic [`DC_INDEX_W-1:0] tag_index;
  logic                  tag_we;
  logic                  tag_dirty;
  logic [`DC_TAG_W-1:0]  tag_value;

  dc_waddr_t             data_addr;
  logic                  data_we;
  logic [`DC_XLEN-1:0]   data_wdata;
  logic [`DC_XLEN/8-1:0] data_strb;
  logic [`DC_XLEN-1:0]   rdata_word;

  dcache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cpu_req_i     (cpu_req_i),
    .cpu_resp_o    (cpu_resp_o),
    .mem_rd_req_o  (mem_rd_req_o),
    .mem_rd_rsp_i  (mem_rd_rsp_i),
    .mem_wr_req_o  (mem_wr_req_o),
    .mem_wr_rsp_i  (mem_wr_rsp_i),
    .hit_i         (hit),
    .victim_tag_i  (victim_tag),
    .victim_dirty_i(victim_dirty),
    .rdata_word_i  (rdata_word),
    .tag_index_o   (tag_index),
    .tag_we_o      (tag_we),
    .tag_dirty_o   (tag_dirty),
    .tag_value_o   (tag_value),
    .data_addr_o   (data_addr),
    .data_we_o     (data_we),
    .data_wdata_o  (data_wdata),
    .data_strb_o   (data_strb)
  );

  dcache_tag_array u_tag (
    .clk           (clk),
    .rst           (rst),
    .index_i       (tag_index),
    .tag_i         (tag_value),
    .we_i          (tag_we),
    .dirty_i       (tag_dirty),
    .hit_o         (hit),
    .victim_tag_o  (victim_tag),
    .victim_dirty_o(victim_dirty)
  );

  dcache_data_array u_data (
    .clk    (clk),
    .addr_i (data_addr),
    .we_i   (data_we),
    .wdata_i(data_wdata),
    .strb_i (data_strb),
    .rdata_o(rdata_word)
  );

endmodule

// File: testbench/mem_model.sv
`timescale 1ns/1ps

module mem_model (
  input  logic                    clk,
  input  logic                    rst,
  input  dcache_pkg::mem_rd_req_t rd_req_i,
  output dcache_pkg::mem_rd_rsp_t rd_rsp_o,
  input  dcache_pkg::mem_wr_req_t wr_req_i,
  output dcache_pkg::mem_wr_rsp_t wr_rsp_o
);
  import dcache_pkg::*;

  logic [31:0] mem [logic [29:0]];  // word address keyed
  logic [31:0] seed = 32'd59;
  logic [1:0]  low_cnt;
  logic        ready_q;
  logic [3:0]  rd_beat;
  logic [3:0]  wr_beat;

  function automatic logic [31:0] init_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ a ^ 32'hc3a5_0f1e;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] a);
    return mem.exists(a[31:2]) ? mem[a[31:2]] : init_word({a[31:2], 2'b00});
  endfunction

  always_comb begin
    rd_rsp_o.ready = ready_q;
    rd_rsp_o.data  = word_at(rd_req_i.addr + {26'd0, rd_beat, 2'b00});
    wr_rsp_o.ready = ready_q;
  end

  always @(posedge clk) begin
    logic [31:0] a;
    logic [31:0] w;
    seed = seed * 32'd1103515245 + 32'd12345;
    if (rst) begin
      ready_q <= 1'b0;
      low_cnt <= '0;
      rd_beat <= '0;
      wr_beat <= '0;
    end else begin
      if (low_cnt == 2'd3 || seed[17:16] != 2'b00) begin  // at most 3 stall cycles
        ready_q <= 1'b1;
        low_cnt <= '0;
      end else begin
        ready_q <= 1'b0;
        low_cnt <= low_cnt + 2'd1;
      end
      if (rd_req_i.valid && ready_q) begin
        rd_beat <= (rd_beat == rd_req_i.len) ? 4'd0 : rd_beat + 4'd1;
      end
      if (wr_req_i.valid && ready_q) begin
        a = wr_req_i.addr + {26'd0, wr_beat, 2'b00};
        w = word_at(a);
        for (int b = 0; b < 4; b++) begin
          if (wr_req_i.strb[b]) w[b*8 +: 8] = wr_req_i.data[b*8 +: 8];
        end
        mem[a[31:2]] = w;
        wr_beat <= (wr_beat == wr_req_i.len) ? 4'd0 : wr_beat + 4'd1;
      end
    end
  end

endmodule

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
  import dcache_pkg::*;

  localparam int NUM_OPS = 300;

  logic        clk = 1'b0;
  logic        rst;
  cpu_req_t    cpu_req;
  cpu_resp_t   cpu_resp;
  mem_rd_req_t mem_rd_req;
  mem_rd_rsp_t mem_rd_rsp;
  mem_wr_req_t mem_wr_req;
  mem_wr_rsp_t mem_wr_rsp;

  logic [31:0] shadow [logic [29:0]];
  logic [21:0] line_tag [16];  // tag resident at each index
  logic [31:0] exp_rdata;
  logic [31:0] exp_wb_addr;
  logic [31:0] exp_wb_data;
  logic        expect_hit;
  logic [3:0]  wb_beat;

  always #20 clk = ~clk;

  dcache_top u_dcache_top (
    .clk(clk), .rst(rst), .cpu_req_i(cpu_req), .cpu_resp_o(cpu_resp),
    .mem_rd_req_o(mem_rd_req), .mem_rd_rsp_i(mem_rd_rsp),
    .mem_wr_req_o(mem_wr_req), .mem_wr_rsp_i(mem_wr_rsp)
  );

  mem_model u_mem (
    .clk(clk), .rst(rst), .rd_req_i(mem_rd_req), .rd_rsp_o(mem_rd_rsp),
    .wr_req_i(mem_wr_req), .wr_rsp_o(mem_wr_rsp)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // same start contents as the memory model
  function automatic logic [31:0] shadow_word(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    return shadow.exists(a[31:2]) ? shadow[a[31:2]] : {w[15:0], w[31:16]} ^ w ^ 32'hc3a5_0f1e;
  endfunction

  task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic fail_text(input string why);
    $display("%0t %s", $time, why);
    $display("Errors found");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    if (rst) wb_beat <= '0;
    else if (mem_wr_req.valid && mem_wr_rsp.ready && mem_wr_req.len == 4'd15)
      wb_beat <= wb_beat + 4'd1;
  end

  // victim line is whatever sits at the requested index
  always @(negedge clk) begin
    exp_wb_addr = {line_tag[cpu_req.addr.flat[9:6]], cpu_req.addr.flat[9:6], 6'd0};
    exp_wb_data = shadow_word(exp_wb_addr + {26'd0, wb_beat, 2'b00});
  end

  a_read_data: assert property (@(posedge clk) disable iff (rst)
    cpu_resp.done && !cpu_req.write |-> cpu_resp.rdata == exp_rdata)
    else fail_value("cpu_resp.rdata", $sampled(cpu_resp.rdata), $sampled(exp_rdata));

  a_hit_latency: assert property (@(posedge clk) disable iff (rst)
    $rose(cpu_req.valid) && expect_hit |=> cpu_resp.done && !mem_rd_req.valid && !mem_wr_req.valid)
    else fail_text("repeat access to a line did not finish as a one cycle hit");

  a_wb_data: assert property (@(posedge clk) disable iff (rst)
    mem_wr_req.valid && mem_wr_rsp.ready && mem_wr_req.len == 4'd15 |->
    mem_wr_req.data == exp_wb_data)
    else fail_value("mem_wr_req.data", $sampled(mem_wr_req.data), $sampled(exp_wb_data));

  a_wb_addr: assert property (@(posedge clk) disable iff (rst)
    mem_wr_req.valid && mem_wr_req.len == 4'd15 |-> mem_wr_req.addr == exp_wb_addr)
    else fail_value("mem_wr_req.addr", $sampled(mem_wr_req.addr), $sampled(exp_wb_addr));

  a_wb_strb: assert property (@(posedge clk) disable iff (rst)
    mem_wr_req.valid && mem_wr_req.len == 4'd15 |-> mem_wr_req.strb == 4'hf)
    else fail_value("mem_wr_req.strb", {28'd0, $sampled(mem_wr_req.strb)}, 32'hf);

  a_refill_addr: assert property (@(posedge clk) disable iff (rst)
    mem_rd_req.valid && mem_rd_req.len == 4'd15 |->
    mem_rd_req.addr == {cpu_req.addr.flat[31:6], 6'd0})
    else fail_value("mem_rd_req.addr", $sampled(mem_rd_req.addr),
                    {$sampled(cpu_req.addr.flat[31:6]), 6'd0});

  a_rd_hold: assert property (@(posedge clk) disable iff (rst)
    mem_rd_req.valid && !mem_rd_rsp.ready |=> mem_rd_req.valid && $stable(mem_rd_req.addr))
    else fail_text("read request changed while stalled");

  a_wr_hold: assert property (@(posedge clk) disable iff (rst)
    mem_wr_req.valid && !mem_wr_rsp.ready |=>
    mem_wr_req.valid && $stable(mem_wr_req.addr) && $stable(mem_wr_req.data))
    else fail_text("write request changed while stalled");

  a_unc_addr: assert property (@(posedge clk) disable iff (rst)
    mem_wr_req.valid && mem_wr_req.len == 4'd0 |-> mem_wr_req.addr == cpu_req.addr.flat)
    else fail_value("mem_wr_req.addr", $sampled(mem_wr_req.addr), $sampled(cpu_req.addr.flat));

  a_unc_strb: assert property (@(posedge clk) disable iff (rst)
    mem_wr_req.valid && mem_wr_req.len == 4'd0 |-> mem_wr_req.strb == cpu_req.strb)
    else fail_value("mem_wr_req.strb", {28'd0, $sampled(mem_wr_req.strb)},
                    {28'd0, $sampled(cpu_req.strb)});

  initial begin
    #(NUM_OPS * 140 * 40);
    fail_text("timeout, a request never completed");
  end

  initial begin
    logic [31:0] seed;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] w;
    logic [21:0] tag;
    logic [25:0] last_line;
    logic        have_last;
    cpu_req_t    nxt;
    seed = 32'd59;
    have_last = 1'b0;
    last_line = '0;
    line_tag = '{default: '0};
    rst = 1'b1;
    cpu_req = '0;
    exp_rdata = '0;
    expect_hit = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < NUM_OPS; n++) begin
      seed = lcg_next(seed);
      r = seed;
      tag = (r[25:24] == 2'd0) ? 22'h100 : (r[25:24] == 2'd1) ? 22'h200 : 22'h300;
      if (r[31:29] == 3'd0) addr = {4'ha, 22'd0, r[21:18], 2'b00};  // device region
      else addr = {tag, 2'b00, r[23:22], r[21:18], 2'b00};
      nxt = '0;
      nxt.valid = 1'b1;
      nxt.write = r[16];
      nxt.addr.flat = addr;
      nxt.strb = (r[15:12] == 4'd0) ? 4'hf : r[15:12];
      seed = lcg_next(seed);
      nxt.wdata = seed;
      @(posedge clk);
      cpu_req <= nxt;
      exp_rdata <= shadow_word(addr);
      expect_hit <= addr[31:28] != 4'ha && have_last && addr[31:6] == last_line;
      if (addr[31:28] != 4'ha) begin
        have_last = 1'b1;
        last_line = addr[31:6];
      end
      do @(posedge clk); while (!cpu_resp.done);
      if (nxt.write) begin
        w = shadow_word(addr);
        for (int b = 0; b < 4; b++) begin
          if (nxt.strb[b]) w[b*8 +: 8] = nxt.wdata[b*8 +: 8];
        end
        shadow[addr[31:2]] = w;
      end
      if (addr[31:28] != 4'ha) begin
        line_tag[addr[9:6]] = addr[31:10];
      end
      cpu_req.valid <= 1'b0;
      expect_hit <= 1'b0;
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: project.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
testbench/mem_model.sv
testbench/dcache_tb.sv

// File: Makefile
SIM_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert -f project.f --top-module dcache_tb \
		--Mdir $(SIM_DIR) -o dcache_sim
	./$(SIM_DIR)/dcache_sim

clean:
	rm -rf $(SIM_DIR)
